//--- project.f
verilog/memAccessPkg.sv
verilog/memGeometryPkg.sv
verilog/storeMerge.sv
verilog/loadExtract.sv
verilog/wordRam.sv
verilog/memAccessCtrl.sv
verilog/dataMemSys.sv
verif/memAccess_checker.sv
verif/memScoreboard.sv
verif/dataMemSys_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the data memory testbench with Verilator and run it
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module dataMemSys_tb \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench prints its summary
simOut=$(./obj_dir/simv +verilator+error+limit+1000)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- verif/dataMemSys_tb.sv
////////////////////
// Data memory subsystem testbench
// Clock, reset, stimulus table, req/ack driver, timeout
////////////////////
`timescale 1ns/1ps

module dataMemSys_tb;
    import memAccessPkg::*;

    localparam int depthWords  = 64;
    localparam int resetCycles = 4;
    localparam int numEntries  = 35;

    typedef struct packed {
        logic        write;
        accessSizeT  size;
        logic        signExt;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        rnd;       // Store data from the xorshift sequence
        logic        expErr;    // Expected fault flag
        logic [3:0]  hold;      // Cycles req stays high after ack
    } stimT;

    // write, size, signExt, addr, wdata, rnd, expErr, hold
    localparam stimT stimTable [numEntries] = '{
        '{1'b1, sizeWord, 1'b0, 32'h0000_0000, 32'h1234_5678, 1'b0, 1'b0, 4'd0},
        '{1'b1, sizeWord, 1'b0, 32'h0000_00FC, 32'h0000_0000, 1'b1, 1'b0, 4'd0},  // Last word
        '{1'b1, sizeWord, 1'b0, 32'h0000_0040, 32'h0000_0000, 1'b1, 1'b0, 4'd2},
        '{1'b0, sizeWord, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeWord, 1'b0, 32'h0000_0040, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeWord, 1'b0, 32'h0000_00FC, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b1, sizeByte, 1'b0, 32'h0000_0010, 32'h0000_0081, 1'b0, 1'b0, 4'd0},  // Four lanes
        '{1'b1, sizeByte, 1'b0, 32'h0000_0011, 32'h0000_007F, 1'b0, 1'b0, 4'd0},
        '{1'b1, sizeByte, 1'b0, 32'h0000_0012, 32'h0000_00C3, 1'b0, 1'b0, 4'd0},
        '{1'b1, sizeByte, 1'b0, 32'h0000_0013, 32'h0000_0024, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeWord, 1'b0, 32'h0000_0010, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeByte, 1'b1, 32'h0000_0010, 32'h0000_0000, 1'b0, 1'b0, 4'd0},  // Negative byte
        '{1'b0, sizeByte, 1'b0, 32'h0000_0010, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeByte, 1'b1, 32'h0000_0011, 32'h0000_0000, 1'b0, 1'b0, 4'd0},  // Positive byte
        '{1'b0, sizeByte, 1'b1, 32'h0000_0012, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeByte, 1'b0, 32'h0000_0012, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeByte, 1'b1, 32'h0000_0013, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b1, sizeWord, 1'b0, 32'h0000_0020, 32'hAAAA_5555, 1'b0, 1'b0, 4'd0},
        '{1'b1, sizeHalf, 1'b0, 32'h0000_0020, 32'h0000_8001, 1'b0, 1'b0, 4'd0},  // Low half only
        '{1'b0, sizeWord, 1'b0, 32'h0000_0020, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeHalf, 1'b1, 32'h0000_0020, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeHalf, 1'b0, 32'h0000_0020, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b1, sizeHalf, 1'b0, 32'h0000_0022, 32'h0000_7FFE, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeHalf, 1'b1, 32'h0000_0022, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b0, sizeWord, 1'b0, 32'h0000_0020, 32'h0000_0000, 1'b0, 1'b0, 4'd0},
        '{1'b1, sizeHalf, 1'b0, 32'h0000_0021, 32'h0000_FFFF, 1'b0, 1'b1, 4'd0},  // Odd half
        '{1'b1, sizeWord, 1'b0, 32'h0000_0022, 32'hFFFF_FFFF, 1'b0, 1'b1, 4'd0},
        '{1'b1, sizeWord, 1'b0, 32'h0000_0100, 32'hDEAD_BEEF, 1'b0, 1'b1, 4'd0},  // Word 64
        '{1'b0, sizeHalf, 1'b1, 32'h0000_0023, 32'h0000_0000, 1'b0, 1'b1, 4'd0},
        '{1'b0, sizeWord, 1'b0, 32'h0000_0400, 32'h0000_0000, 1'b0, 1'b1, 4'd1},
        '{1'b0, sizeWord, 1'b0, 32'h0000_0020, 32'h0000_0000, 1'b0, 1'b0, 4'd0},  // Unchanged
        '{1'b0, sizeWord, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 4'd0},  // Word 64 alias
        '{1'b0, sizeWord, 1'b0, 32'h0000_00FC, 32'h0000_0000, 1'b0, 1'b0, 4'd3},
        '{1'b1, sizeByte, 1'b0, 32'h0000_00FF, 32'h0000_0000, 1'b1, 1'b0, 4'd4},
        '{1'b0, sizeWord, 1'b0, 32'h0000_00FC, 32'h0000_0000, 1'b0, 1'b0, 4'd0}
    };

    logic        Clk;
    logic        rst;
    logic        req;
    logic        ack;
    memReqT      memReq;
    memRespT     memResp;
    logic        expErr;
    logic [31:0] randState;
    int          sbErrors;
    int          sbResps;
    int          cycleCount = 0;
    int          cycleLimit = 0;    // Set once the table is scanned

    dataMemSys #(.depthWords(depthWords)) dut0 (
        .Clk(Clk), .rst(rst), .req(req), .ack(ack), .memReq(memReq), .memResp(memResp)
    );

    memScoreboard #(.depthWords(depthWords)) sb0 (
        .Clk(Clk), .rst(rst), .ack(ack), .memReq(memReq), .memResp(memResp),
        .expErr(expErr), .errCount(sbErrors), .respCount(sbResps)
    );

    bind dataMemSys memAccessChecker chk0 (
        .Clk(Clk), .rst(rst), .req(req), .ack(ack), .memReq(memReq)
    );

    initial Clk = 1'b0;
    always #10 Clk = ~Clk;   // 20 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One four phase handshake, called right after a rising edge
    task automatic driveAccess(input stimT s, input logic [31:0] data);
        memReqT r;
        r.write   = s.write;
        r.size    = s.size;
        r.signExt = s.signExt;
        r.addr    = s.addr;
        r.wdata   = data;
        req    <= 1'b1;
        memReq <= r;
        expErr <= s.expErr;
        do begin
            @(posedge Clk);
        end while (!ack);
        repeat (s.hold) @(posedge Clk);   // Back pressure
        req <= 1'b0;
        do begin
            @(posedge Clk);
        end while (ack);
    endtask

    // Ends a stalled run
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        int          maxHold;
        int          seqErrors;
        int          totalErrors;
        logic [31:0] data;
        maxHold   = 0;
        seqErrors = 0;
        rst       <= 1'b1;
        req       <= 1'b0;
        memReq    <= '0;
        expErr    <= 1'b0;
        randState = 32'h485937b1;
        for (int i = 0; i < numEntries; i++) begin
            if (int'(stimTable[i].hold) > maxHold) begin
                maxHold = int'(stimTable[i].hold);
            end
        end
        cycleLimit = numEntries * (6 + maxHold) + resetCycles;
        repeat (resetCycles) @(posedge Clk);
        rst <= 1'b0;
        @(posedge Clk);
        for (int i = 0; i < numEntries; i++) begin
            data = stimTable[i].wdata;
            if (stimTable[i].rnd) begin
                randState = xorshift32(randState);
                data      = randState;
            end
            driveAccess(stimTable[i], data);
        end
        repeat (2) @(posedge Clk);
        if (sbResps != numEntries) begin
            $display("Only %0d of %0d accesses got a response", sbResps, numEntries);
            seqErrors++;
        end
        totalErrors = sbErrors + dut0.chk0.assertFails + seqErrors;
        $display("Error counts: scoreboard %0d, assertions %0d, sequencing %0d",
                 sbErrors, dut0.chk0.assertFails, seqErrors);
        if (totalErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verif/memAccess_checker.sv
////////////////////
// Handshake assertions on the data memory top
// Bound into dataMemSys by the testbench
////////////////////
`timescale 1ns/1ps

module memAccessChecker (
    input logic                 Clk,
    input logic                 rst,
    input logic                 req,
    input logic                 ack,
    input memAccessPkg::memReqT memReq
);

    int assertFails = 0;   // Failed assertion count, read at the end of the run

    // Reset leaves ack low
    ackLowAfterReset: assert property (@(posedge Clk) rst |=> !ack)
        else begin
            $error("ack is high in the cycle after reset");
            assertFails++;
        end

    // Controller sees req at the first sample, ack is set two edges later
    // and is seen high at the third sample
    ackLatency: assert property (@(posedge Clk) disable iff (rst) $rose(req) |-> ##3 $rose(ack))
        else begin
            $error("ack did not rise exactly two edges after req was accepted");
            assertFails++;
        end

    ackHeldWhileReq: assert property (@(posedge Clk) disable iff (rst) (req && ack) |=> ack)
        else begin
            $error("ack fell while req was still high");
            assertFails++;
        end

    // Master must not change the request mid handshake
    reqStable: assert property (@(posedge Clk) disable iff (rst) req |=> $stable(memReq))
        else begin
            $error("memReq changed while req was high");
            assertFails++;
        end

endmodule

//--- verif/memScoreboard.sv
////////////////////
// Response checker for the data memory
// Byte level memory model, expected memResp per access
////////////////////
`timescale 1ns/1ps

module memScoreboard #(
    parameter int depthWords = 64
) (
    input  logic                  Clk,
    input  logic                  rst,
    input  logic                  ack,
    input  memAccessPkg::memReqT  memReq,
    input  memAccessPkg::memRespT memResp,
    input  logic                  expErr,      // Fault flag from the stimulus table
    output int                    errCount,
    output int                    respCount
);
    import memAccessPkg::*;

    logic [7:0]  model [depthWords*4];   // Little endian, byte 0 is lane 0
    logic        ackPrev;
    logic        afterReset;
    logic        fault;
    logic [31:0] expData;
    memRespT     heldResp;                // Response seen when ack rose

    // Alignment and range rules of the subsystem
    function automatic logic isFault(input memReqT r);
        logic misal;
        misal = (r.size == sizeHalf && r.addr[0]) || (r.size == sizeWord && r.addr[1:0] != 2'b00);
        return misal || ((r.addr >> 2) >= 32'(depthWords));
    endfunction

    function automatic logic [31:0] loadValue(input memReqT r);
        int          a;
        logic [31:0] v;
        a = int'(r.addr);
        case (r.size)
            sizeByte: v = {{24{r.signExt & model[a][7]}}, model[a]};
            sizeHalf: v = {{16{r.signExt & model[a+1][7]}}, model[a+1], model[a]};
            default:  v = {model[a+3], model[a+2], model[a+1], model[a]};
        endcase
        return v;
    endfunction

    task automatic applyStore(input memReqT r);
        int a;
        a = int'(r.addr);
        model[a] = r.wdata[7:0];                  // Every size writes its low byte
        if (r.size != sizeByte) begin
            model[a+1] = r.wdata[15:8];
        end
        if (r.size == sizeWord) begin
            model[a+2] = r.wdata[23:16];
            model[a+3] = r.wdata[31:24];
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expV, input logic [31:0] actV);
        if (actV !== expV) begin
            $display("ERROR at %0t: %s expected 0x%08h actual 0x%08h", $time, name, expV, actV);
            errCount++;
        end
    endtask

    always @(posedge Clk) begin
        if (rst) begin
            ackPrev    = 1'b0;
            afterReset = 1'b1;
            errCount   = 0;
            respCount  = 0;
        end else begin
            if (afterReset) begin
                checkValue("memResp.rdata after reset", 32'd0, memResp.rdata);
                checkValue("memResp.err after reset", 32'd0, 32'(memResp.err));
                checkValue("ack after reset", 32'd0, 32'(ack));
            end
            if (ack && !ackPrev) begin
                // New response, request is still held by the master
                respCount++;
                fault   = isFault(memReq);
                expData = 32'd0;                  // Stores and faults read back zero
                if (!fault && !memReq.write) begin
                    expData = loadValue(memReq);
                end
                checkValue("memResp.rdata", expData, memResp.rdata);
                checkValue("memResp.err", 32'(expErr), 32'(memResp.err));
                if (!fault && memReq.write) begin
                    applyStore(memReq);
                end
                heldResp = memResp;
            end else if (ack && ackPrev) begin
                checkValue("memResp.rdata held", heldResp.rdata, memResp.rdata);
                checkValue("memResp.err held", 32'(heldResp.err), 32'(memResp.err));
            end
            ackPrev    = ack;
            afterReset = 1'b0;
        end
    end

endmodule

//--- verilog/dataMemSys.sv
////////////////////
// Data memory subsystem top
// Controller, store merge, word RAM, load extract
////////////////////
`timescale 1ns/1ps

module dataMemSys #(
    parameter int depthWords = 64
) (
    input  logic                  Clk,
    input  logic                  rst,
    input  logic                  req,
    output logic                  ack,
    input  memAccessPkg::memReqT  memReq,
    output memAccessPkg::memRespT memResp
);
    import memGeometryPkg::*;

    localparam int addrW = $clog2(depthWords);

    logic [addrW-1:0] wordAddr;
    logic             rdEn;
    logic             wrEn;
    byteEnT           byteEn;      // Lanes touched by a store
    logic [31:0]      wdataLane;   // Store data replicated onto lanes
    logic             misaligned;
    logic [31:0]      rdWord;      // Registered RAM output
    logic [31:0]      loadData;    // Extended load value

    memAccessCtrl #(.depthWords(depthWords)) ctrl0 (
        .Clk(Clk), .rst(rst),
        .req(req), .ack(ack),
        .memReq(memReq), .misaligned(misaligned), .loadData(loadData),
        .wordAddr(wordAddr), .rdEn(rdEn), .wrEn(wrEn),
        .memResp(memResp)
    );

    storeMerge merge0 (
        .memReq(memReq), .byteEn(byteEn), .wdataLane(wdataLane), .misaligned(misaligned)
    );

    wordRam #(.depthWords(depthWords)) ram0 (
        .Clk(Clk), .wordAddr(wordAddr), .rdEn(rdEn), .wrEn(wrEn),
        .byteEn(byteEn), .wrWord(wdataLane), .rdWord(rdWord)
    );

    // Lane and size come straight from the held request
    loadExtract extract0 (
        .rdWord(rdWord), .lane(memReq.addr[laneBits-1:0]),
        .size(memReq.size), .signExt(memReq.signExt), .loadData(loadData)
    );

endmodule

//--- verilog/loadExtract.sv
////////////////////
// Load lane select
// Zero or sign fill of byte and halfword loads
////////////////////
`timescale 1ns/1ps

module loadExtract (
    input  logic [31:0]               rdWord,
    input  memGeometryPkg::laneIdxT   lane,
    input  memAccessPkg::accessSizeT  size,
    input  logic                      signExt,
    output logic [31:0]               loadData
);
    import memAccessPkg::*;

    logic [7:0]  byteSel;   // Addressed byte
    logic [15:0] halfSel;   // Addressed halfword
    logic        byteFill;
    logic        halfFill;

    // Lane 0 is bits 7:0, lane 3 is bits 31:24
    always_comb begin
        case (lane)
            2'd0:    byteSel = rdWord[7:0];
            2'd1:    byteSel = rdWord[15:8];
            2'd2:    byteSel = rdWord[23:16];
            default: byteSel = rdWord[31:24];
        endcase
    end

    assign halfSel = lane[1] ? rdWord[31:16] : rdWord[15:0];   // Lane bit 0 ignored here

    // Fill bit is the field's top bit only for signed loads
    assign byteFill = signExt & byteSel[7];
    assign halfFill = signExt & halfSel[15];

    always_comb begin
        case (size)
            sizeByte: begin
                loadData = {{24{byteFill}}, byteSel};
            end
            sizeHalf: begin
                loadData = {{16{halfFill}}, halfSel};
            end
            default: begin
                // Whole word, nothing to extend
                loadData = rdWord;
            end
        endcase
    end

endmodule

//--- verilog/memAccessCtrl.sv
////////////////////
// Four phase req/ack FSM
// Range check, RAM sequencing, response capture
////////////////////
`timescale 1ns/1ps

module memAccessCtrl #(
    parameter int depthWords = 64
) (
    input  logic                          Clk,
    input  logic                          rst,
    input  logic                          req,
    output logic                          ack,
    input  memAccessPkg::memReqT          memReq,
    input  logic                          misaligned,
    input  logic [31:0]                   loadData,
    output logic [$clog2(depthWords)-1:0] wordAddr,
    output logic                          rdEn,
    output logic                          wrEn,
    output memAccessPkg::memRespT         memResp
);
    import memAccessPkg::*;
    import memGeometryPkg::*;

    localparam int addrW = $clog2(depthWords);

    typedef enum logic [1:0] {
        stIdle,      // Waiting for req
        stAccess,    // RAM enables high for one cycle
        stRespond,   // Capture, then ack high until req drops
        stRelease    // Drop ack
    } ctrlStateT;

    ctrlStateT          state;
    logic [31-laneBits:0] fullWordAddr;   // Byte address divided by four
    logic               outOfRange;
    logic               fault;
    memRespT            respNext;

    assign fullWordAddr = memReq.addr[31:laneBits];
    assign outOfRange   = 32'(fullWordAddr) >= 32'(depthWords);
    assign fault        = misaligned | outOfRange;   // Faults touch no memory
    assign wordAddr     = fullWordAddr[addrW-1:0];

    assign rdEn = (state == stAccess) && !memReq.write && !fault;
    assign wrEn = (state == stAccess) &&  memReq.write && !fault;

    // Response for the current request
    always_comb begin
        respNext = '0;
        if (fault) begin
            respNext.err = 1'b1;          // rdata stays zero
        end else if (!memReq.write) begin
            respNext.rdata = loadData;    // Read word valid in the first respond cycle
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state   <= stIdle;
            ack     <= 1'b0;
            memResp <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (req) begin
                        state <= stAccess;
                    end
                end
                stAccess: begin
                    state <= stRespond;   // RAM write or read happens at this edge
                end
                stRespond: begin
                    if (!ack) begin
                        ack     <= 1'b1;   // Two edges after req was seen
                        memResp <= respNext;
                    end else if (!req) begin
                        state <= stRelease;
                    end
                end
                default: begin
                    ack   <= 1'b0;
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

//--- verilog/memAccessPkg.sv
////////////////////
// Access size encoding
// Request and response structs of the req/ack handshake
////////////////////

package memAccessPkg;

    // Same encoding as the BHW field of the MIPS data memory
    typedef enum logic [1:0] {
        sizeByte = 2'd0,    // lb, lbu, sb
        sizeHalf = 2'd1,    // lh, lhu, sh
        sizeWord = 2'd2     // lw, sw
    } accessSizeT;

    // One access as held by the master for the whole handshake
    typedef struct packed {
        logic       write;      // 1 store, 0 load
        accessSizeT size;
        logic       signExt;    // Loads only
        logic [31:0] addr;      // Byte address
        logic [31:0] wdata;     // Store data, right aligned
    } memReqT;

    // Returned with ack
    // Stores and faults carry zero rdata
    typedef struct packed {
        logic [31:0] rdata;     // Extracted load value
        logic        err;       // Misaligned or out of range
    } memRespT;

endpackage

//--- verilog/memGeometryPkg.sv
////////////////////
// Byte lane types
// Word geometry constants
////////////////////

package memGeometryPkg;

    localparam int wordBytes = 4;                   // Bytes per RAM word
    localparam int laneBits  = $clog2(wordBytes);   // Low address bits that pick a lane

    // One enable per byte lane, bit 0 is bits 7:0 of the word
    typedef logic [wordBytes-1:0] byteEnT;

    // Lane index taken from addr[1:0]
    typedef logic [laneBits-1:0] laneIdxT;

endpackage

//--- verilog/storeMerge.sv
////////////////////
// Store lane decode
// Byte enables, lane replicated write word, misalignment flag
////////////////////
`timescale 1ns/1ps

module storeMerge (
    input  memAccessPkg::memReqT   memReq,
    output memGeometryPkg::byteEnT byteEn,
    output logic [31:0]            wdataLane,
    output logic                   misaligned
);
    import memAccessPkg::*;
    import memGeometryPkg::*;

    laneIdxT lane;

    assign lane = memReq.addr[laneBits-1:0];   // Low address bits pick the lane

    always_comb begin
        byteEn     = '0;
        wdataLane  = memReq.wdata;
        misaligned = 1'b0;
        case (memReq.size)
            sizeByte: begin
                // Any lane is legal for a byte
                byteEn    = byteEnT'(4'b0001 << lane);
                wdataLane = {wordBytes{memReq.wdata[7:0]}};     // Same byte on every lane
            end
            sizeHalf: begin
                // Lane bit 1 picks upper or lower half
                if (lane[1]) begin
                    byteEn = 4'b1100;
                end else begin
                    byteEn = 4'b0011;
                end
                wdataLane  = {2{memReq.wdata[15:0]}};
                misaligned = lane[0];                           // Odd address
            end
            sizeWord: begin
                byteEn     = 4'b1111;
                wdataLane  = memReq.wdata;
                misaligned = (lane != 2'b00);
            end
            default: begin
                // Size code 3 is not an access, let it fault
                byteEn     = '0;
                misaligned = 1'b1;
            end
        endcase
    end

endmodule

//--- verilog/wordRam.sv
////////////////////
// Word RAM with per byte write enables
// Registered read port
////////////////////
`timescale 1ns/1ps

module wordRam #(
    parameter int depthWords = 64
) (
    input  logic                          Clk,
    input  logic [$clog2(depthWords)-1:0] wordAddr,
    input  logic                          rdEn,
    input  logic                          wrEn,
    input  memGeometryPkg::byteEnT        byteEn,
    input  logic [31:0]                   wrWord,
    output logic [31:0]                   rdWord
);
    import memGeometryPkg::*;

    logic [31:0] mem [depthWords];   // Contents undefined until written

    // Only enabled lanes change, the rest of the word is kept
    always_ff @(posedge Clk) begin
        if (wrEn) begin
            for (int i = 0; i < wordBytes; i++) begin
                if (byteEn[i]) begin
                    mem[wordAddr][8*i +: 8] <= wrWord[8*i +: 8];
                end
            end
        end
    end

    // Read data valid one edge after rdEn
    always_ff @(posedge Clk) begin
        if (rdEn) begin
            rdWord <= mem[wordAddr];   // Holds last read otherwise
        end
    end

endmodule
